// File: src/cache_pkg.sv
package cache_pkg;

    // Processor address and data word widths
    localparam int ADDR_W = 48;
    localparam int WORD_W = 24;

    // Default geometry: 16 words per line, 16 lines
    localparam int OFF_BITS_DEF = 4;
    localparam int IDX_BITS_DEF = 4;

    // Refill sequencer states
    // REFILL_ISSUE pulses the backing request once the port is granted,
    // REFILL_WAIT holds until the beat's b_valid comes back
    typedef enum logic [1:0] {
        REFILL_IDLE  = 2'd0,
        REFILL_ISSUE = 2'd1,
        REFILL_WAIT  = 2'd2
    } refill_state_e;

endpackage

// File: src/tag_store.sv
`timescale 1ns/10ps

module tag_store #(
    parameter int OFF_BITS = cache_pkg::OFF_BITS_DEF,
    parameter int IDX_BITS = cache_pkg::IDX_BITS_DEF,
    localparam int TAG_BITS = cache_pkg::ADDR_W - OFF_BITS - IDX_BITS
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [cache_pkg::ADDR_W-1:0] lookup_addr,
    input  logic                        line_fill,
    input  logic [IDX_BITS-1:0]         fill_idx,
    input  logic [TAG_BITS-1:0]         fill_tag,
    output logic                        hit
);

    localparam int NUM_LINES = 1 << IDX_BITS;

    logic [NUM_LINES-1:0] valid;
    logic [TAG_BITS-1:0]  tags [NUM_LINES];

    logic [IDX_BITS-1:0]  lookup_idx;
    logic [TAG_BITS-1:0]  lookup_tag;

    // Split the front address, offset bits are not needed here
    assign lookup_idx = lookup_addr[OFF_BITS +: IDX_BITS];
    assign lookup_tag = lookup_addr[cache_pkg::ADDR_W-1 -: TAG_BITS];

    assign hit = valid[lookup_idx] && (tags[lookup_idx] == lookup_tag);

    // Valid bits start cleared so every line misses after reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
        end else if (line_fill) begin
            valid[fill_idx] <= 1'b1;
        end
    end

    // Tag written together with the valid bit on the last refill beat
    always_ff @(posedge clk) begin
        if (line_fill) begin
            tags[fill_idx] <= fill_tag;
        end
    end

endmodule

// File: src/data_store.sv
`timescale 1ns/10ps

module data_store #(
    parameter int OFF_BITS = cache_pkg::OFF_BITS_DEF,
    parameter int IDX_BITS = cache_pkg::IDX_BITS_DEF
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [IDX_BITS+OFF_BITS-1:0]  rd_addr,
    input  logic                          stall,
    input  logic                          store_hit,
    input  logic [cache_pkg::WORD_W-1:0]  wdata,
    input  logic                          fill_we,
    input  logic [IDX_BITS-1:0]           fill_idx,
    input  logic [OFF_BITS-1:0]           fill_off,
    input  logic [cache_pkg::WORD_W-1:0]  fill_data,
    output logic [cache_pkg::WORD_W-1:0]  rdata
);

    localparam int NUM_WORDS = 1 << (IDX_BITS + OFF_BITS);

    logic [cache_pkg::WORD_W-1:0] mem [NUM_WORDS];

    // Refill beats and store hits never coincide since a store hit
    // needs stall low and refill beats only arrive while stalled
    always_ff @(posedge clk) begin
        if (fill_we) begin
            mem[{fill_idx, fill_off}] <= fill_data;
        end else if (store_hit) begin
            mem[rd_addr] <= wdata;
        end
    end

    // One-cycle registered read, frozen while a refill is running
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdata <= '0;
        end else if (!stall) begin
            rdata <= mem[rd_addr];
        end
    end

endmodule

// File: src/refill_ctrl.sv
`timescale 1ns/10ps

module refill_ctrl #(
    parameter int OFF_BITS = cache_pkg::OFF_BITS_DEF,
    parameter int IDX_BITS = cache_pkg::IDX_BITS_DEF,
    localparam int TAG_BITS = cache_pkg::ADDR_W - OFF_BITS - IDX_BITS
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [cache_pkg::ADDR_W-1:0] f_addr,
    input  logic                         f_we,
    input  logic                         hit,
    input  logic                         b_valid,
    input  logic [cache_pkg::WORD_W-1:0] b_rdata,
    input  logic                         rf_grant,
    output logic                         stall,
    output logic                         store_hit,
    output logic                         rf_req,
    output logic [cache_pkg::ADDR_W-1:0] rf_addr,
    output logic                         fill_we,
    output logic [IDX_BITS-1:0]          fill_idx,
    output logic [OFF_BITS-1:0]          fill_off,
    output logic [cache_pkg::WORD_W-1:0] fill_data,
    output logic                         line_fill,
    output logic [TAG_BITS-1:0]          fill_tag
);

    cache_pkg::refill_state_e state;

    logic [IDX_BITS-1:0] miss_idx;
    logic [TAG_BITS-1:0] miss_tag;
    logic [OFF_BITS-1:0] beat_cnt;
    logic                read_miss;
    logic                last_beat;

    // Only loads allocate, a store miss just writes through
    assign read_miss = (state == cache_pkg::REFILL_IDLE) && !f_we && !hit;
    assign last_beat = &beat_cnt;

    assign stall     = (state != cache_pkg::REFILL_IDLE);
    assign store_hit = hit && f_we && !stall;

    // Beat address is the line base plus the beat count
    assign rf_req  = (state == cache_pkg::REFILL_ISSUE);
    assign rf_addr = {miss_tag, miss_idx, {OFF_BITS{1'b0}}}
                   + {{(cache_pkg::ADDR_W-OFF_BITS){1'b0}}, beat_cnt};

    // Each returned word goes straight into the data array
    assign fill_we   = (state == cache_pkg::REFILL_WAIT) && b_valid;
    assign fill_idx  = miss_idx;
    assign fill_off  = beat_cnt;
    assign fill_data = b_rdata;
    assign line_fill = fill_we && last_beat;
    assign fill_tag  = miss_tag;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= cache_pkg::REFILL_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                cache_pkg::REFILL_IDLE: begin
                    if (read_miss) begin
                        state    <= cache_pkg::REFILL_ISSUE;
                        beat_cnt <= '0;
                    end
                end
                cache_pkg::REFILL_ISSUE: begin
                    // Held here while the write-through buffer drains
                    if (rf_grant) begin
                        state <= cache_pkg::REFILL_WAIT;
                    end
                end
                cache_pkg::REFILL_WAIT: begin
                    if (b_valid) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (last_beat) begin
                            state <= cache_pkg::REFILL_IDLE;
                        end else begin
                            state <= cache_pkg::REFILL_ISSUE;
                        end
                    end
                end
                default: begin
                    state <= cache_pkg::REFILL_IDLE;
                end
            endcase
        end
    end

    // Line being refilled
    always_ff @(posedge clk) begin
        if (read_miss) begin
            miss_idx <= f_addr[OFF_BITS +: IDX_BITS];
            miss_tag <= f_addr[cache_pkg::ADDR_W-1 -: TAG_BITS];
        end
    end

endmodule

// File: src/wt_buffer.sv
`timescale 1ns/10ps

module wt_buffer (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         f_we,
    input  logic [cache_pkg::ADDR_W-1:0] f_addr,
    input  logic [cache_pkg::WORD_W-1:0] f_wdata,
    input  logic                         stall,
    input  logic                         rf_req,
    input  logic [cache_pkg::ADDR_W-1:0] rf_addr,
    output logic                         rf_grant,
    output logic                         b_req,
    output logic                         b_we,
    output logic [cache_pkg::ADDR_W-1:0] b_addr,
    output logic [cache_pkg::WORD_W-1:0] b_wdata
);

    logic                         pending;
    logic [cache_pkg::ADDR_W-1:0] st_addr;
    logic [cache_pkg::WORD_W-1:0] st_wdata;
    logic                         st_accept;
    logic                         beat_outstanding;

    assign st_accept = f_we && !stall;

    // Stalled with no request means a refill read is in flight
    assign beat_outstanding = stall && !rf_req;

    // Pending store has the port first, refill only gets it when empty
    assign rf_grant = !pending;
    assign b_we     = pending && !beat_outstanding;
    assign b_req    = rf_req && rf_grant;
    assign b_addr   = b_we ? st_addr : rf_addr;
    assign b_wdata  = st_wdata;

    // A new store may load in the same cycle the old one drains
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (st_accept) begin
            pending <= 1'b1;
        end else if (b_we) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (st_accept) begin
            st_addr  <= f_addr;
            st_wdata <= f_wdata;
        end
    end

endmodule

// File: src/dcache_top.sv
`timescale 1ns/10ps

module dcache_top #(
    parameter int OFF_BITS = cache_pkg::OFF_BITS_DEF,
    parameter int IDX_BITS = cache_pkg::IDX_BITS_DEF
) (
    input  logic                         clk,
    input  logic                         rst,
    // Processor side
    input  logic                         f_we,
    input  logic [cache_pkg::ADDR_W-1:0] f_addr,
    input  logic [cache_pkg::WORD_W-1:0] f_wdata,
    output logic [cache_pkg::WORD_W-1:0] f_rdata,
    output logic                         stall,
    // Backing memory side
    output logic                         b_req,
    output logic                         b_we,
    output logic [cache_pkg::ADDR_W-1:0] b_addr,
    output logic [cache_pkg::WORD_W-1:0] b_wdata,
    input  logic                         b_valid,
    input  logic [cache_pkg::WORD_W-1:0] b_rdata
);

    localparam int TAG_BITS = cache_pkg::ADDR_W - OFF_BITS - IDX_BITS;

    logic                         hit;
    logic                         store_hit;
    logic                         line_fill;
    logic [IDX_BITS-1:0]          fill_idx;
    logic [TAG_BITS-1:0]          fill_tag;
    logic                         fill_we;
    logic [OFF_BITS-1:0]          fill_off;
    logic [cache_pkg::WORD_W-1:0] fill_data;
    logic                         rf_req;
    logic [cache_pkg::ADDR_W-1:0] rf_addr;
    logic                         rf_grant;

    tag_store #(
        .OFF_BITS (OFF_BITS),
        .IDX_BITS (IDX_BITS)
    ) u_tag_store (
        .clk         (clk),
        .rst         (rst),
        .lookup_addr (f_addr),
        .line_fill   (line_fill),
        .fill_idx    (fill_idx),
        .fill_tag    (fill_tag),
        .hit         (hit)
    );

    // Word array indexed by the index and offset fields of the front address
    data_store #(
        .OFF_BITS (OFF_BITS),
        .IDX_BITS (IDX_BITS)
    ) u_data_store (
        .clk       (clk),
        .rst       (rst),
        .rd_addr   (f_addr[IDX_BITS+OFF_BITS-1:0]),
        .stall     (stall),
        .store_hit (store_hit),
        .wdata     (f_wdata),
        .fill_we   (fill_we),
        .fill_idx  (fill_idx),
        .fill_off  (fill_off),
        .fill_data (fill_data),
        .rdata     (f_rdata)
    );

    refill_ctrl #(
        .OFF_BITS (OFF_BITS),
        .IDX_BITS (IDX_BITS)
    ) u_refill_ctrl (
        .clk       (clk),
        .rst       (rst),
        .f_addr    (f_addr),
        .f_we      (f_we),
        .hit       (hit),
        .b_valid   (b_valid),
        .b_rdata   (b_rdata),
        .rf_grant  (rf_grant),
        .stall     (stall),
        .store_hit (store_hit),
        .rf_req    (rf_req),
        .rf_addr   (rf_addr),
        .fill_we   (fill_we),
        .fill_idx  (fill_idx),
        .fill_off  (fill_off),
        .fill_data (fill_data),
        .line_fill (line_fill),
        .fill_tag  (fill_tag)
    );

    // Sole owner of the backing port
    wt_buffer u_wt_buffer (
        .clk      (clk),
        .rst      (rst),
        .f_we     (f_we),
        .f_addr   (f_addr),
        .f_wdata  (f_wdata),
        .stall    (stall),
        .rf_req   (rf_req),
        .rf_addr  (rf_addr),
        .rf_grant (rf_grant),
        .b_req    (b_req),
        .b_we     (b_we),
        .b_addr   (b_addr),
        .b_wdata  (b_wdata)
    );

endmodule

// File: tb/backing_mem.sv
`timescale 1ns/10ps

module backing_mem #(
    parameter logic [31:0]                SEED     = 32'h1,
    parameter logic [cache_pkg::WORD_W-1:0] FILL_XOR = '0
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         req,
    input  logic                         we,
    input  logic [cache_pkg::ADDR_W-1:0] addr,
    input  logic [cache_pkg::WORD_W-1:0] wdata,
    output logic                         valid,
    output logic [cache_pkg::WORD_W-1:0] rdata
);

    // Sparse contents, unwritten words follow the fill rule
    logic [cache_pkg::WORD_W-1:0] mem [logic [cache_pkg::ADDR_W-1:0]];

    integer                       seed;
    int                           wait_cnt;
    logic                         busy;
    logic [cache_pkg::ADDR_W-1:0] rd_addr;

    initial begin
        seed = SEED;
    end

    function automatic logic [cache_pkg::WORD_W-1:0] read_word(
        input logic [cache_pkg::ADDR_W-1:0] a
    );
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a[cache_pkg::WORD_W-1:0] ^ FILL_XOR;
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            valid    <= 1'b0;
            rdata    <= '0;
            busy     <= 1'b0;
            wait_cnt <= 0;
            rd_addr  <= '0;
        end else begin
            valid <= 1'b0;
            if (we) begin
                mem[addr] = wdata;
            end
            if (req) begin
                // Read latency of 1 to 4 cycles
                busy     <= 1'b1;
                wait_cnt <= ($random(seed) & 32'h3) + 1;
                rd_addr  <= addr;
            end else if (busy) begin
                if (wait_cnt == 1) begin
                    busy  <= 1'b0;
                    valid <= 1'b1;
                    rdata <= read_word(rd_addr);
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end
        end
    end

endmodule

// File: tb/dcache_properties.sv
`timescale 1ns/10ps

module dcache_properties (
    input  logic clk,
    input  logic rst,
    input  logic b_req,
    input  logic b_we,
    input  logic b_valid,
    input  logic stall
);

    logic [4:0] valid_cnt;
    logic       outstanding;

    // Failed assertions so far, read by the testbench
    int         fail_count = 0;

    // Beats returned during the current refill
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_cnt <= '0;
        end else if (!stall) begin
            valid_cnt <= '0;
        end else if (b_valid) begin
            valid_cnt <= valid_cnt + 5'd1;
        end
    end

    // A refill read is in flight from its request until its b_valid
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            outstanding <= 1'b0;
        end else if (b_req) begin
            outstanding <= 1'b1;
        end else if (b_valid) begin
            outstanding <= 1'b0;
        end
    end

    a_no_req_and_we: assert property (@(posedge clk) disable iff (rst) !(b_req && b_we))
        else begin
            $error("b_req and b_we high together");
            fail_count++;
        end

    a_req_single: assert property (@(posedge clk) disable iff (rst) b_req |=> !b_req)
        else begin
            $error("b_req longer than one cycle");
            fail_count++;
        end

    a_stall_held: assert property (@(posedge clk) disable iff (rst)
        (stall && b_valid && valid_cnt < 5'd15) |=> stall)
        else begin
            $error("stall fell before the last beat");
            fail_count++;
        end

    a_stall_end: assert property (@(posedge clk) disable iff (rst)
        $fell(stall) |-> (valid_cnt == 5'd16))
        else begin
            $error("stall fell without 16 beats");
            fail_count++;
        end

    a_no_we_in_beat: assert property (@(posedge clk) disable iff (rst) outstanding |-> !b_we)
        else begin
            $error("write-through during an outstanding beat");
            fail_count++;
        end

endmodule

bind dcache_top dcache_properties u_dcache_properties (
    .clk     (clk),
    .rst     (rst),
    .b_req   (b_req),
    .b_we    (b_we),
    .b_valid (b_valid),
    .stall   (stall)
);

// File: tb/tb_dcache.sv
`timescale 1ns/10ps

module tb_dcache;

    localparam int AW = cache_pkg::ADDR_W;
    localparam int WW = cache_pkg::WORD_W;
    localparam logic [31:0] SEED     = 32'h9caf23c9;
    localparam logic [WW-1:0] FILL_XOR = 24'h5a5a5a;
    localparam int NUM_OPS = 10;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 200 + 10;

    logic          clk;
    logic          rst;
    logic          f_we;
    logic [AW-1:0] f_addr;
    logic [WW-1:0] f_wdata;
    logic [WW-1:0] f_rdata;
    logic          stall;
    logic          b_req;
    logic          b_we;
    logic [AW-1:0] b_addr;
    logic [WW-1:0] b_wdata;
    logic          b_valid;
    logic [WW-1:0] b_rdata;

    // Operation table
    logic          op_store [NUM_OPS];
    logic [AW-1:0] op_addr [NUM_OPS];
    logic [WW-1:0] op_wdata [NUM_OPS];
    logic          op_stall [NUM_OPS];

    // Expected memory contents, stores only
    logic [WW-1:0] model [logic [AW-1:0]];

    logic [AW-1:0] req_q[$];
    logic [AW-1:0] wt_addr_q[$];
    logic [WW-1:0] wt_data_q[$];
    int            cycles;

    dcache_top #(
        .OFF_BITS (cache_pkg::OFF_BITS_DEF),
        .IDX_BITS (cache_pkg::IDX_BITS_DEF)
    ) u_dcache_top (
        .clk     (clk),
        .rst     (rst),
        .f_we    (f_we),
        .f_addr  (f_addr),
        .f_wdata (f_wdata),
        .f_rdata (f_rdata),
        .stall   (stall),
        .b_req   (b_req),
        .b_we    (b_we),
        .b_addr  (b_addr),
        .b_wdata (b_wdata),
        .b_valid (b_valid),
        .b_rdata (b_rdata)
    );

    backing_mem #(
        .SEED     (SEED),
        .FILL_XOR (FILL_XOR)
    ) u_backing_mem (
        .clk   (clk),
        .rst   (rst),
        .req   (b_req),
        .we    (b_we),
        .addr  (b_addr),
        .wdata (b_wdata),
        .valid (b_valid),
        .rdata (b_rdata)
    );

    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

    // Record backing traffic
    always @(posedge clk) begin
        if (b_req) begin
            req_q.push_back(b_addr);
        end
        if (b_we) begin
            wt_addr_q.push_back(b_addr);
            wt_data_q.push_back(b_wdata);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks failed");
            $fatal(1);
        end
    end

    // Watch the bound assertions between clock edges
    always @(negedge clk) begin
        if (u_dcache_top.u_dcache_properties.fail_count != 0) begin
            $display("A bound assertion on the backing or stall signals failed at %0t ns",
                     $time);
            $display("Checks failed");
            $fatal(1);
        end
    end

    function automatic logic [WW-1:0] expected_word(input logic [AW-1:0] a);
        if (model.exists(a)) begin
            return model[a];
        end
        return a[WW-1:0] ^ FILL_XOR;
    endfunction

    task automatic report_failure(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_word(input string what, input logic [WW-1:0] got,
                              input logic [WW-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("%s got %h expected %h", what, got, exp));
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("%s got %b expected %b", what, got, exp));
        end
    endtask

    task automatic check_addr(input string what, input logic [AW-1:0] got,
                              input logic [AW-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("%s got %h expected %h", what, got, exp));
        end
    endtask

    task automatic check_write(input logic [AW-1:0] got_addr, input logic [WW-1:0] got_data,
                               input logic [AW-1:0] exp_addr, input logic [WW-1:0] exp_data);
        if (got_addr !== exp_addr || got_data !== exp_data) begin
            report_failure($sformatf("write-through got %h/%h expected %h/%h",
                                     got_addr, got_data, exp_addr, exp_data));
        end
    endtask

    task automatic do_read(input int i);
        logic          stalled;
        logic [AW-1:0] base;
        f_we   = 1'b0;
        f_addr = op_addr[i];
        req_q.delete();
        @(posedge clk);
        #1;
        stalled = stall;
        while (stall) begin
            @(posedge clk);
            #1;
        end
        if (stalled) begin
            @(posedge clk);
            #1;
        end
        check_flag($sformatf("op %0d stall", i), stalled, op_stall[i]);
        check_word($sformatf("op %0d read data", i), f_rdata, expected_word(op_addr[i]));
        if (op_stall[i]) begin
            base = op_addr[i] & ~48'hf;
            if (req_q.size() != 16) begin
                report_failure($sformatf("op %0d made %0d refill requests, not 16",
                                         i, req_q.size()));
            end
            for (int k = 0; k < 16; k++) begin
                check_addr($sformatf("op %0d beat %0d address", i, k), req_q[k],
                           base + AW'(k));
            end
        end
    endtask

    task automatic do_store(input int i);
        wt_addr_q.delete();
        wt_data_q.delete();
        f_we    = 1'b1;
        f_addr  = op_addr[i];
        f_wdata = op_wdata[i];
        #2;
        check_flag($sformatf("op %0d stall at store", i), stall, op_stall[i]);
        @(posedge clk);
        #1;
        f_we = 1'b0;
        model[op_addr[i]] = op_wdata[i];
        while (wt_addr_q.size() == 0) begin
            @(posedge clk);
            #1;
        end
        check_write(wt_addr_q[0], wt_data_q[0], op_addr[i], op_wdata[i]);
    endtask

    task automatic set_op(input int i, input logic is_store, input logic [AW-1:0] addr,
                          input logic [WW-1:0] wdata, input logic exp_stall);
        op_store[i] = is_store;
        op_addr[i]  = addr;
        op_wdata[i] = wdata;
        op_stall[i] = exp_stall;
    endtask

    task automatic fill_table();
        // Lines at index 7 (two tags) and index 2
        set_op(0, 1'b0, 48'h0000_1234_5673, 24'h000000, 1'b1);
        set_op(1, 1'b0, 48'h0000_1234_5679, 24'h000000, 1'b0);
        set_op(2, 1'b1, 48'h0000_1234_5675, 24'hc0ffee, 1'b0);
        set_op(3, 1'b0, 48'h0000_1234_5675, 24'h000000, 1'b0);
        set_op(4, 1'b1, 48'h0000_0abc_de22, 24'h123456, 1'b0);
        set_op(5, 1'b0, 48'h0000_0abc_de22, 24'h000000, 1'b1);
        set_op(6, 1'b0, 48'h0000_9999_0071, 24'h000000, 1'b1);
        set_op(7, 1'b0, 48'h0000_1234_5673, 24'h000000, 1'b1);
        set_op(8, 1'b0, 48'h0000_9999_0072, 24'h000000, 1'b1);
        set_op(9, 1'b0, 48'h0000_1234_5675, 24'h000000, 1'b1);
    endtask

    initial begin
        rst     = 1'b1;
        f_we    = 1'b0;
        f_addr  = '0;
        f_wdata = '0;
        cycles  = 0;
        fill_table();
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        check_flag("stall after reset", stall, 1'b0);
        check_flag("b_req after reset", b_req, 1'b0);
        check_flag("b_we after reset", b_we, 1'b0);
        check_word("f_rdata after reset", f_rdata, '0);
        for (int i = 0; i < NUM_OPS; i++) begin
            if (op_store[i]) begin
                do_store(i);
            end else begin
                do_read(i);
            end
        end
        if (u_dcache_top.u_dcache_properties.fail_count == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Checks failed");
            $fatal(1);
        end
    end

endmodule

// File: flist.f
src/cache_pkg.sv
src/tag_store.sv
src/data_store.sv
src/refill_ctrl.sv
src/wt_buffer.sv
src/dcache_top.sv
tb/backing_mem.sv
tb/dcache_properties.sv
tb/tb_dcache.sv

// File: Makefile
VERILATOR ?= verilator
FLIST     ?= flist.f
TOP       ?= tb_dcache
RTL_TOP   ?= dcache_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= All checks passed

RTL_SRCS := $(filter src/%,$(shell cat $(FLIST)))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FLIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
